// ==== Makefile ====
# Verilator build and run of the AHB-Lite memory subordinate testbench

VERILATOR ?= verilator
TOP       ?= tbAhbSub
FILELIST  ?= compile.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)
BIN  := $(OBJDIR)/V$(TOP)

.PHONY: all run check clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi

check: run
	@grep -q "TESTS PASSED" $(LOG) || { echo "No pass result in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== compile.f ====
+incdir+include
src/ahbPkg.sv
src/subMemPkg.sv
src/burstAddrGen.sv
src/transferCtrl.sv
src/subMem.sv
src/ahbSubordinate.sv
sim/tbAhbSub.sv

// ==== include/ahbSub_settings.svh ====
// Build-wide constants for the AHB-Lite memory subordinate
// Bus widths, memory depth and the testbench watchdog

`ifndef AHBSUB_SETTINGS_SVH
`define AHBSUB_SETTINGS_SVH

// Bus widths
`define AHB_ADDR_WIDTH 32
`define AHB_DATA_WIDTH 32

// Word storage, byte addresses 0 to 1023
`define MEM_DEPTH_WORDS 256

// Watchdog in HCLK cycles, covers all tests with margin
`define TB_CYCLE_LIMIT 4000

`endif

// ==== sim/tbAhbSub.sv ====
// Testbench for the AHB-Lite memory subordinate
// Clock, reset, LFSR stimulus, byte-array reference model,
// pipelined bus driver, assertions and per-test reporting

`timescale 1ns/100ps
`include "ahbSub_settings.svh"

module tbAhbSub;
  import ahbPkg::*;

  localparam int MemBytes  = `MEM_DEPTH_WORDS * 4;
  localparam int ByteAddrW = $clog2(MemBytes);

  logic                       HCLK;
  logic                       HRESETn;
  logic                       HSEL;
  logic [`AHB_ADDR_WIDTH-1:0] HADDR;
  htransT                     HTRANS;
  logic                       HWRITE;
  hsizeT                      HSIZE;
  hburstT                     HBURST;
  logic [3:0]                 HPROT;
  logic [`AHB_DATA_WIDTH-1:0] HWDATA;
  logic                       HREADYin;
  logic [`AHB_DATA_WIDTH-1:0] HRDATA;
  hrespT                      HRESP;
  logic                       HREADYout;

  logic [7:0]  model [MemBytes];
  logic [31:0] lfsrState;
  int          errCount     = 0;
  int          testStartErr = 0;
  int          testsRun     = 0;
  int          testsPassed  = 0;
  int          cycleCount   = 0;

  // Beat whose data phase comes next
  logic        pValid;
  logic        pWrite;
  logic        pErr;
  hsizeT       pSize;
  logic [31:0] pAddr;
  logic [31:0] pWdata;

  assign HREADYin = HREADYout;  // Single subordinate

  ahbSubordinate ahbSubordinate_inst (.*);

  initial begin
    HCLK = 1'b0;
    forever #20 HCLK = ~HCLK;
  end

  always @(posedge HCLK) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= `TB_CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, the tests did not finish", cycleCount);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // --------------------
  // Two-cycle ERROR response
  errorWaitState: assert property (@(posedge HCLK) disable iff (!HRESETn)
    !HREADYout |-> HRESP == ERROR)
    else begin
      errCount++;
      $display("HREADYout went low without an ERROR response at %0t", $time);
    end
  errorSecondCycle: assert property (@(posedge HCLK) disable iff (!HRESETn)
    !HREADYout |=> (HREADYout && HRESP == ERROR))
    else begin
      errCount++;
      $display("ERROR response did not end with HREADYout high and HRESP ERROR at %0t", $time);
    end

  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
      lfsrState = {lfsrState[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  // Byte lanes used by a transfer
  function automatic logic laneOn(input logic [ByteAddrW-1:0] a, input hsizeT sz, input int i);
    case (sz)
      BYTE:     return (2'(i) == a[1:0]);
      HALFWORD: return ((i / 2) == int'(a[1]));
      default:  return 1'b1;
    endcase
  endfunction

  function automatic logic [31:0] expRead(input logic [ByteAddrW-1:0] a, input hsizeT sz);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < 4; i++) begin
      if (laneOn(a, sz, i)) v[8*i +: 8] = model[{a[ByteAddrW-1:2], 2'(i)}];
    end
    return v;
  endfunction

  task automatic modelWrite(input logic [ByteAddrW-1:0] a, input hsizeT sz, input logic [31:0] wd);
    for (int i = 0; i < 4; i++) begin
      if (laneOn(a, sz, i)) model[{a[ByteAddrW-1:2], 2'(i)}] = wd[8*i +: 8];
    end
  endtask

  task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("MISMATCH %s: got %h, expected %h at %0t", name, got, exp, $time);
      errCount++;
    end
  endtask

  // --------------------
  // Data phase checks sampled at the falling edge
  task automatic retire();
    if (!pValid) begin
      checkVal("HREADYout", 32'(HREADYout), 32'h1);
      checkVal("HRESP", 32'(HRESP), 32'(OKAY));
      checkVal("HRDATA", HRDATA, 32'h0);
    end else if (pErr) begin
      checkVal("HREADYout", 32'(HREADYout), 32'h0);
      checkVal("HRESP", 32'(HRESP), 32'(ERROR));
      @(posedge HCLK);
      @(negedge HCLK);
      checkVal("HREADYout", 32'(HREADYout), 32'h1);
      checkVal("HRESP", 32'(HRESP), 32'(ERROR));
    end else begin
      checkVal("HREADYout", 32'(HREADYout), 32'h1);
      checkVal("HRESP", 32'(HRESP), 32'(OKAY));
      if (pWrite) begin
        checkVal("HRDATA", HRDATA, 32'h0);
        modelWrite(pAddr[ByteAddrW-1:0], pSize, pWdata);
      end else begin
        checkVal("HRDATA", HRDATA, expRead(pAddr[ByteAddrW-1:0], pSize));
      end
    end
  endtask

  // One address phase; an error beat must be followed by IDLE
  task automatic issue(input htransT tr, input logic wr, input hsizeT sz, input hburstT bu,
                       input logic [3:0] pr, input logic [31:0] ad, input logic [31:0] modelAd,
                       input logic [31:0] wd, input logic err);
    @(posedge HCLK);
    HSEL   <= 1'b1;
    HTRANS <= tr;
    HWRITE <= wr;
    HSIZE  <= sz;
    HBURST <= bu;
    HPROT  <= pr;
    HADDR  <= ad;
    HWDATA <= pWdata;   // Data of the previous beat
    @(negedge HCLK);
    retire();
    pValid = tr[1];
    pWrite = wr;
    pErr   = err;
    pSize  = sz;
    pAddr  = modelAd;
    pWdata = wd;
  endtask

  task automatic single(input logic wr, input hsizeT sz, input logic [3:0] pr, input hburstT bu,
                        input logic [31:0] ad, input logic [31:0] wd, input logic err);
    issue(NONSEQ, wr, sz, bu, pr, ad, ad, wd, err);
  endtask

  task automatic idle();
    issue(IDLE, 1'b0, WORD, SINGLE, 4'b0011, 32'h0, 32'h0, 32'h0, 1'b0);
  endtask

  // Word burst with random HADDR on SEQ beats and a BUSY before the third beat
  task automatic incrBurst(input logic wr, input hburstT bu, input logic [31:0] start,
                           input int beats);
    htransT      tr;
    logic [31:0] ad;
    for (int i = 0; i < beats; i++) begin
      if (i == 0) begin
        tr = NONSEQ;
        ad = start;
      end else begin
        tr = SEQ;
        ad = randBits(32);
      end
      if (i == 2) issue(BUSY, wr, WORD, bu, 4'b0011, randBits(32), 32'h0, 32'h0, 1'b0);
      issue(tr, wr, WORD, bu, 4'b0011, ad, start + 32'(4 * i), randBits(32), 1'b0);
    end
  endtask

  task automatic endTest(input string name);
    testsRun++;
    if (errCount == testStartErr) begin
      testsPassed++;
      $display("PASS  %s", name);
    end else begin
      $display("FAIL  %s, %0d errors", name, errCount - testStartErr);
    end
    testStartErr = errCount;
  endtask

  // --------------------
  initial begin
    logic [31:0] addrs [8];
    logic [31:0] a;
    HRESETn = 1'b0;
    HSEL    = 1'b0;
    HADDR   = '0;
    HTRANS  = IDLE;
    HWRITE  = 1'b0;
    HSIZE   = WORD;
    HBURST  = SINGLE;
    HPROT   = 4'b0000;
    HWDATA  = '0;
    lfsrState = 32'h34a4_28d1;
    pValid = 1'b0;
    pWrite = 1'b0;
    pErr   = 1'b0;
    pSize  = WORD;
    pAddr  = '0;
    pWdata = '0;
    for (int k = 0; k < MemBytes; k++) model[k] = 8'h00;
    repeat (8) @(posedge HCLK);
    HRESETn <= 1'b1;

    @(negedge HCLK);
    checkVal("HREADYout", 32'(HREADYout), 32'h1);
    checkVal("HRESP", 32'(HRESP), 32'(OKAY));
    checkVal("HRDATA", HRDATA, 32'h0);
    for (int i = 0; i < 4; i++) single(1'b0, WORD, 4'b0011, SINGLE, randBits(8) << 2, 32'h0, 1'b0);
    idle();
    endTest("reset state");

    for (int i = 0; i < 8; i++) begin
      addrs[i] = randBits(8) << 2;
      single(1'b1, WORD, 4'b0011, SINGLE, addrs[i], randBits(32), 1'b0);
    end
    for (int i = 0; i < 8; i++) single(1'b0, WORD, 4'b0011, SINGLE, addrs[i], 32'h0, 1'b0);
    idle();
    endTest("single words");

    a = 32'h100 + (randBits(6) << 2);
    single(1'b1, WORD, 4'b0011, SINGLE, a, randBits(32), 1'b0);
    single(1'b1, BYTE, 4'b0011, SINGLE, a + 1, randBits(32), 1'b0);
    single(1'b1, HALFWORD, 4'b0011, SINGLE, a + 2, randBits(32), 1'b0);
    single(1'b0, WORD, 4'b0011, SINGLE, a, 32'h0, 1'b0);
    single(1'b0, BYTE, 4'b0011, SINGLE, a + 3, 32'h0, 1'b0);
    single(1'b0, HALFWORD, 4'b0011, SINGLE, a, 32'h0, 1'b0);
    single(1'b0, BYTE, 4'b0011, SINGLE, a + 1, 32'h0, 1'b0);
    idle();
    endTest("byte and halfword lanes");

    a = 32'h200 + (randBits(6) << 2);
    incrBurst(1'b1, INCR4, a, 4);
    incrBurst(1'b1, INCR, a + 16, 3);
    idle();
    incrBurst(1'b0, INCR, a, 7);
    idle();
    endTest("INCR bursts");

    a = 32'h300 + (randBits(6) << 2);
    single(1'b1, WORD, 4'b0011, SINGLE, a, randBits(32), 1'b0);
    single(1'b1, WORD, 4'b0001, SINGLE, a, randBits(32), 1'b1);   // User-mode write
    idle();
    single(1'b0, WORD, 4'b0011, SINGLE, a, 32'h0, 1'b0);
    single(1'b0, WORD, 4'b0001, SINGLE, a, 32'h0, 1'b0);
    idle();
    endTest("unprivileged write");

    // Aliases onto the word at a if the range check were missing
    single(1'b1, WORD, 4'b0011, SINGLE, a + 32'h400, randBits(32), 1'b1);
    idle();
    single(1'b1, HALFWORD, 4'b0011, SINGLE, a + 1, randBits(32), 1'b1);
    idle();
    single(1'b1, SIZE64, 4'b0011, SINGLE, a, randBits(32), 1'b1);
    idle();
    single(1'b1, WORD, 4'b0011, WRAP4, a, randBits(32), 1'b1);
    idle();
    single(1'b0, WORD, 4'b0011, SINGLE, a, 32'h0, 1'b0);
    idle();
    endTest("rejected transfers");

    $display("%0d of %0d tests passed, %0d errors", testsPassed, testsRun, errCount);
    if (errCount == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== src/ahbPkg.sv ====
// AHB-Lite protocol encodings
// Transfer type, burst type, transfer size and response enums

package ahbPkg;

  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htransT;

  typedef enum logic [2:0] {
    SINGLE = 3'b000,
    INCR   = 3'b001,
    WRAP4  = 3'b010,
    INCR4  = 3'b011,
    WRAP8  = 3'b100,
    INCR8  = 3'b101,
    WRAP16 = 3'b110,
    INCR16 = 3'b111
  } hburstT;

  // Codes above WORD only exist so they can be rejected
  typedef enum logic [2:0] {
    BYTE     = 3'b000,
    HALFWORD = 3'b001,
    WORD     = 3'b010,
    SIZE64   = 3'b011,
    SIZE128  = 3'b100,
    SIZE256  = 3'b101,
    SIZE512  = 3'b110,
    SIZE1024 = 3'b111
  } hsizeT;

  typedef enum logic {
    OKAY  = 1'b0,
    ERROR = 1'b1
  } hrespT;

endpackage

// ==== src/ahbSubordinate.sv ====
// AHB-Lite memory subordinate, top level
// Burst address generator, transfer control and word memory

`timescale 1ns/100ps
`include "ahbSub_settings.svh"

module ahbSubordinate (
  input  logic                       HCLK,
  input  logic                       HRESETn,
  input  logic                       HSEL,
  input  logic [`AHB_ADDR_WIDTH-1:0] HADDR,
  input  ahbPkg::htransT             HTRANS,
  input  logic                       HWRITE,
  input  ahbPkg::hsizeT              HSIZE,
  input  ahbPkg::hburstT             HBURST,
  input  logic [3:0]                 HPROT,
  input  logic [`AHB_DATA_WIDTH-1:0] HWDATA,
  input  logic                       HREADYin,
  output logic [`AHB_DATA_WIDTH-1:0] HRDATA,
  output ahbPkg::hrespT              HRESP,
  output logic                       HREADYout
);
  import ahbPkg::*;

  localparam int WordIdxW = $clog2(`MEM_DEPTH_WORDS);

  logic                         accept;
  logic                         seqBeat;
  hsizeT                        beatSize;
  logic [`AHB_ADDR_WIDTH-1:0]   beatAddr;   // Full width so the range check sees every bit
  logic                         wrEn;
  logic                         rdEn;
  logic [WordIdxW-1:0]          dataAddr;
  logic [`AHB_DATA_WIDTH/8-1:0] laneMask;

  burstAddrGen burstAddrGen_inst (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .accept    (accept),
    .seqBeat   (seqBeat),
    .beatSize  (beatSize),
    .startAddr (HADDR),
    .beatAddr  (beatAddr)
  );

  transferCtrl transferCtrl_inst (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .HSEL      (HSEL),
    .HTRANS    (HTRANS),
    .HWRITE    (HWRITE),
    .HSIZE     (HSIZE),
    .HBURST    (HBURST),
    .HPROT     (HPROT),
    .HREADYin  (HREADYin),
    .beatAddr  (beatAddr),
    .accept    (accept),
    .seqBeat   (seqBeat),
    .beatSize  (beatSize),
    .wrEn      (wrEn),
    .rdEn      (rdEn),
    .dataAddr  (dataAddr),
    .laneMask  (laneMask),
    .HRESP     (HRESP),
    .HREADYout (HREADYout)
  );

  subMem subMem_inst (
    .HCLK     (HCLK),
    .HRESETn  (HRESETn),
    .wrEn     (wrEn),
    .rdEn     (rdEn),
    .dataAddr (dataAddr),
    .laneMask (laneMask),
    .HWDATA   (HWDATA),
    .HRDATA   (HRDATA)
  );

endmodule

// ==== src/burstAddrGen.sv ====
// Beat address generator for incrementing bursts
// NONSEQ loads the start address, SEQ advances by the beat size

`timescale 1ns/100ps
`include "ahbSub_settings.svh"

module burstAddrGen (
  input  logic                       HCLK,
  input  logic                       HRESETn,
  input  logic                       accept,
  input  logic                       seqBeat,
  input  ahbPkg::hsizeT              beatSize,
  input  logic [`AHB_ADDR_WIDTH-1:0] startAddr,
  output logic [`AHB_ADDR_WIDTH-1:0] beatAddr
);
  import ahbPkg::*;
  import subMemPkg::*;

  localparam int AddrW = `AHB_ADDR_WIDTH;

  logic [AddrW-1:0] lastAddr;   // Running burst address
  logic [AddrW-1:0] beatBytes;

  // Byte count of one beat
  always_comb begin
    case (beatSize)
      BYTE:     beatBytes = AddrW'(1);
      HALFWORD: beatBytes = AddrW'(2);
      default:  beatBytes = AddrW'($bits(laneMaskT));  // Full word
    endcase
  end

  // HADDR is ignored on SEQ beats
  assign beatAddr = seqBeat ? (lastAddr + beatBytes) : startAddr;

  // --------------------
  // BUSY and IDLE leave the address alone
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      lastAddr <= '0;
    end else if (accept) begin
      lastAddr <= beatAddr;
    end
  end

endmodule

// ==== src/subMem.sv ====
// Word storage for the memory subordinate
// Byte-lane merged writes, lane-masked combinational reads

`timescale 1ns/100ps
`include "ahbSub_settings.svh"

module subMem (
  input  logic                                HCLK,
  input  logic                                HRESETn,
  input  logic                                wrEn,
  input  logic                                rdEn,
  input  logic [$clog2(`MEM_DEPTH_WORDS)-1:0] dataAddr,
  input  subMemPkg::laneMaskT                 laneMask,
  input  logic [`AHB_DATA_WIDTH-1:0]          HWDATA,
  output logic [`AHB_DATA_WIDTH-1:0]          HRDATA
);
  import subMemPkg::*;

  localparam int Lanes = $bits(laneMaskT);

  logic [`AHB_DATA_WIDTH-1:0] mem [`MEM_DEPTH_WORDS];
  logic [`AHB_DATA_WIDTH-1:0] laneBits;   // Lane mask widened to bits

  always_comb begin
    for (int i = 0; i < Lanes; i++) begin
      laneBits[8*i +: 8] = {8{laneMask[i]}};
    end
  end

  // --------------------
  // Write at the edge that ends the data phase
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      for (int w = 0; w < `MEM_DEPTH_WORDS; w++) begin
        mem[w] <= '0;
      end
    end else if (wrEn) begin
      // Old bytes kept outside the enabled lanes
      mem[dataAddr] <= (HWDATA & laneBits) | (mem[dataAddr] & ~laneBits);
    end
  end

  // Bytes stay in their AHB lanes, the rest read zero
  assign HRDATA = rdEn ? (mem[dataAddr] & laneBits) : '0;

endmodule

// ==== src/subMemPkg.sv ====
// Internal types of the memory subordinate
// Data-phase state enum and byte lane mask

`include "ahbSub_settings.svh"

package subMemPkg;

  // --------------------
  // Data-phase FSM
  typedef enum logic [2:0] {
    IDLE       = 3'b000,
    WRITE      = 3'b001,
    READ       = 3'b010,
    ERR_FIRST  = 3'b011,  // HREADYout low
    ERR_SECOND = 3'b100   // HREADYout high
  } ctrlStateT;

  // --------------------
  // One enable per byte lane of the data bus
  typedef logic [`AHB_DATA_WIDTH/8-1:0] laneMaskT;

endpackage

// ==== src/transferCtrl.sv ====
// Transfer control for the memory subordinate
// Address-phase checks, data-phase FSM, lane mask and
// the OKAY or two-cycle ERROR response

`timescale 1ns/100ps
`include "ahbSub_settings.svh"

module transferCtrl (
  input  logic                                HCLK,
  input  logic                                HRESETn,
  input  logic                                HSEL,
  input  ahbPkg::htransT                      HTRANS,
  input  logic                                HWRITE,
  input  ahbPkg::hsizeT                       HSIZE,
  input  ahbPkg::hburstT                      HBURST,
  input  logic [3:0]                          HPROT,
  input  logic                                HREADYin,
  input  logic [`AHB_ADDR_WIDTH-1:0]          beatAddr,
  output logic                                accept,
  output logic                                seqBeat,
  output ahbPkg::hsizeT                       beatSize,
  output logic                                wrEn,
  output logic                                rdEn,
  output logic [$clog2(`MEM_DEPTH_WORDS)-1:0] dataAddr,
  output subMemPkg::laneMaskT                 laneMask,
  output ahbPkg::hrespT                       HRESP,
  output logic                                HREADYout
);
  import ahbPkg::*;
  import subMemPkg::*;

  localparam int WordIdxW = $clog2(`MEM_DEPTH_WORDS);
  localparam int AddrW    = `AHB_ADDR_WIDTH;

  ctrlStateT state;
  ctrlStateT nextState;
  logic      errHold;     // Burst already failed, SEQ beats stay rejected until IDLE
  logic      aligned;
  logic      inRange;
  logic      privOk;
  logic      transferOk;
  laneMaskT  nextMask;

  // --------------------
  // Address phase
  assign accept   = HSEL && HREADYin && HTRANS[1];  // NONSEQ or SEQ
  assign seqBeat  = (HTRANS == SEQ);
  assign beatSize = HSIZE;

  // Sizes above WORD never count as aligned
  always_comb begin
    case (HSIZE)
      BYTE:     aligned = 1'b1;
      HALFWORD: aligned = ~beatAddr[0];
      WORD:     aligned = (beatAddr[1:0] == 2'b00);
      default:  aligned = 1'b0;
    endcase
  end

  assign inRange    = (beatAddr < AddrW'(`MEM_DEPTH_WORDS * 4));
  assign privOk     = HPROT[0] && (!HWRITE || HPROT[1]);  // Reads at any level
  assign transferOk = privOk && aligned && inRange
                      && !(HBURST inside {WRAP4, WRAP8, WRAP16})
                      && !(seqBeat && errHold);

  always_comb begin
    case (HSIZE)
      BYTE:     nextMask = 4'b0001 << beatAddr[1:0];
      HALFWORD: nextMask = beatAddr[1] ? 4'b1100 : 4'b0011;
      default:  nextMask = 4'b1111;
    endcase
  end

  // --------------------
  // Data-phase FSM
  always_comb begin
    nextState = state;
    if (state == ERR_FIRST) begin
      nextState = ERR_SECOND;
    end else if (HREADYin) begin
      if (!accept) begin
        nextState = subMemPkg::IDLE;
      end else if (!transferOk) begin
        nextState = ERR_FIRST;
      end else begin
        nextState = HWRITE ? WRITE : READ;
      end
    end
  end

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      state   <= subMemPkg::IDLE;
      errHold <= 1'b0;
    end else begin
      state <= nextState;
      if (HREADYin) begin
        if (accept && !transferOk) begin
          errHold <= 1'b1;
        end else if (HTRANS == ahbPkg::IDLE || (accept && !seqBeat)) begin
          errHold <= 1'b0;
        end
      end
    end
  end

  // Word index and lanes carried into the data phase
  always_ff @(posedge HCLK) begin
    if (accept) begin
      dataAddr <= beatAddr[WordIdxW+1:2];
      laneMask <= nextMask;
    end
  end

  // --------------------
  // Response
  assign wrEn      = (state == WRITE);
  assign rdEn      = (state == READ);
  assign HREADYout = (state != ERR_FIRST);
  assign HRESP     = (state == ERR_FIRST || state == ERR_SECOND) ? ERROR : OKAY;

endmodule
